/* hw/ex_macros.svh */
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Datapath word width
`define EX_XLEN 32

// Multiply runs one shift-and-add step per cycle
`define EX_MUL_CYCLES 32

// Divide runs one restoring step per cycle
// plus a final cycle that applies the signs
`define EX_DIV_CYCLES 33

// GPR written by the link forms of jump and branch
`define EX_LINK_REG 31

`endif

/* hw/ex_data_pkg.sv */
`include "ex_macros.svh"

package ex_data_pkg;

	// Fields handed over by decode
	typedef struct packed {
		logic [15:0]          imm;
		logic [4:0]           sa;
		logic [4:0]           rs;
		logic [4:0]           rt;
		logic [4:0]           rd;
		logic [`EX_XLEN-1:0]  pc;
	} dp_dtoe;

	// Results passed on to the memory stage
	typedef struct packed {
		logic [`EX_XLEN-1:0]  ex_out;
		logic [4:0]           reg_waddr;
		logic                 intovf;
		// Store data rides along unchanged
		logic [`EX_XLEN-1:0]  rtdata;
		logic [`EX_XLEN-1:0]  pc;
	} dp_etom;

	// Status seen by the hazard unit
	typedef struct packed {
		logic [4:0]           reg_waddr;
		logic                 regwrite;
		logic [4:0]           rs;
		logic [4:0]           rt;
		// Stall source while a multiply or divide is running
		logic                 muldiv_busy;
	} dp_etoh;

endpackage

/* hw/ex_ctrl_pkg.sv */
package ex_ctrl_pkg;

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_addu = 4'd1,
		alu_sub  = 4'd2,
		alu_subu = 4'd3,
		alu_and  = 4'd4,
		alu_or   = 4'd5,
		alu_xor  = 4'd6,
		alu_nor  = 4'd7,
		alu_slt  = 4'd8,
		alu_sltu = 4'd9,
		alu_lui  = 4'd10
	} alu_func_e;

	typedef enum logic [1:0] {
		sft_sll = 2'd0,
		sft_srl = 2'd1,
		sft_sra = 2'd2
	} sft_func_e;

	// Source of the stage result
	typedef enum logic [2:0] {
		out_alu   = 3'd0,
		out_shift = 3'd1,
		out_hi    = 3'd2,
		out_lo    = 3'd3,
		out_count = 3'd4,
		out_rs    = 3'd5
	} out_sel_e;

	typedef enum logic [1:0] {
		regdst_rt   = 2'd0,
		regdst_rd   = 2'd1,
		regdst_link = 2'd2
	} regdst_e;

	typedef enum logic [2:0] {
		br_beq  = 3'd0,
		br_bne  = 3'd1,
		br_bgez = 3'd2,
		br_bgtz = 3'd3,
		br_blez = 3'd4,
		br_bltz = 3'd5
	} branch_e;

	// Decoded control word for one instruction in execute
	typedef struct packed {
		alu_func_e  alu_func;
		sft_func_e  sft_func;
		out_sel_e   out_sel;
		regdst_e    regdst;
		branch_e    branch;
		logic       imm_sign;
		logic       alu_srcb_sel_rt;
		logic       sft_srca_sel_imm;
		logic       sft_srcb_sel_rs;
		logic       cl_mode;
		logic       isbranch;
		logic       intovf_en;
		logic       mul_en;
		logic       div_en;
		logic       md_sign;
		logic       hi_wen;
		logic       lo_wen;
		logic       regwrite;
	} ctrl_reg;

endpackage

/* hw/alu.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module alu (
	input  ex_ctrl_pkg::alu_func_e  func,
	input  logic [`EX_XLEN-1:0]     srca,
	input  logic [`EX_XLEN-1:0]     srcb,
	output logic [`EX_XLEN-1:0]     result,
	output logic                    intovf
);
	import ex_ctrl_pkg::*;

	localparam int msb = `EX_XLEN - 1;

	logic [`EX_XLEN-1:0] sum;
	logic [`EX_XLEN-1:0] diff;
	logic                ovf_add;
	logic                ovf_sub;
	logic                lt_s;
	logic                lt_u;

	assign sum  = srca + srcb;
	assign diff = srca - srcb;

	// Overflow when the operands agree in sign and the sum does not
	assign ovf_add = (srca[msb] == srcb[msb]) && (sum[msb] != srca[msb]);
	// For subtract the operand signs must differ instead
	assign ovf_sub = (srca[msb] != srcb[msb]) && (diff[msb] != srca[msb]);

	assign lt_s = $signed(srca) < $signed(srcb);
	assign lt_u = srca < srcb;

	always_comb begin
		result = '0;
		intovf = 1'b0;
		case (func)
			alu_add: begin
				result = sum;
				intovf = ovf_add;
			end
			alu_addu: result = sum;
			alu_sub: begin
				result = diff;
				intovf = ovf_sub;
			end
			alu_subu: result = diff;
			alu_and:  result = srca & srcb;
			alu_or:   result = srca | srcb;
			alu_xor:  result = srca ^ srcb;
			alu_nor:  result = ~(srca | srcb);
			alu_slt:  result = {{(`EX_XLEN-1){1'b0}}, lt_s};
			alu_sltu: result = {{(`EX_XLEN-1){1'b0}}, lt_u};
			// Immediate goes to the upper half
			alu_lui:  result = {srcb[15:0], {(`EX_XLEN-16){1'b0}}};
			default:  result = '0;
		endcase
	end

endmodule

/* hw/bit_unit.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module bit_unit (
	input  ex_ctrl_pkg::sft_func_e  sft_func,
	input  logic [`EX_XLEN-1:0]     shift_src,
	input  logic [4:0]              shamt,
	input  logic                    cl_mode,
	input  logic [`EX_XLEN-1:0]     cl_src,
	output logic [`EX_XLEN-1:0]     shift_out,
	output logic [`EX_XLEN-1:0]     count_out
);
	import ex_ctrl_pkg::*;

	// Wide enough to hold a full-word count
	localparam int cnt_w = $clog2(`EX_XLEN) + 1;

	logic [`EX_XLEN-1:0] norm;
	logic [cnt_w-1:0]    lead;
	logic                found;

	always_comb begin
		case (sft_func)
			sft_sll: shift_out = shift_src << shamt;
			sft_srl: shift_out = shift_src >> shamt;
			sft_sra: shift_out = $unsigned($signed(shift_src) >>> shamt);
			default: shift_out = '0;
		endcase
	end

	// Leading ones become leading zeros after inversion
	assign norm = cl_mode ? ~cl_src : cl_src;

	always_comb begin
		lead  = '0;
		found = 1'b0;
		for (int i = `EX_XLEN - 1; i >= 0; i--) begin
			if (norm[i]) begin
				found = 1'b1;
			end else if (!found) begin
				lead = lead + 1'b1;
			end
		end
	end

	assign count_out = {{(`EX_XLEN-cnt_w){1'b0}}, lead};

endmodule

/* hw/muldiv.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module muldiv (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic                is_div,
	input  logic                sign,
	input  logic [`EX_XLEN-1:0] srca,
	input  logic [`EX_XLEN-1:0] srcb,
	output logic                busy,
	output logic                done,
	output logic [`EX_XLEN-1:0] hi,
	output logic [`EX_XLEN-1:0] lo
);
	localparam int xlen  = `EX_XLEN;
	localparam int cnt_w = $clog2(`EX_DIV_CYCLES);

	logic [cnt_w-1:0]  cnt;
	logic              op_div;
	logic              neg_q;
	logic              neg_r;
	logic [xlen-1:0]   opd;
	logic [2*xlen-1:0] acc;
	logic [xlen-1:0]   mag_a;
	logic [xlen-1:0]   mag_b;
	logic [xlen:0]     mul_sum;
	logic [2*xlen-1:0] mul_next;
	logic [2*xlen-1:0] mul_res;
	logic [xlen:0]     div_rem;
	logic [xlen:0]     div_diff;
	logic [2*xlen-1:0] div_next;
	logic [xlen-1:0]   quo_fix;
	logic [xlen-1:0]   rem_fix;

	assign mag_a = (sign && srca[xlen-1]) ? -srca : srca;
	assign mag_b = (sign && srcb[xlen-1]) ? -srcb : srcb;

	// Multiplier bits retire from the low end of acc
	assign mul_sum  = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, opd} : '0);
	assign mul_next = {mul_sum, acc[xlen-1:1]};
	assign mul_res  = neg_q ? -mul_next : mul_next;

	// Upper half is the partial remainder, lower half the dividend and quotient
	assign div_rem  = {acc[2*xlen-1:xlen], acc[xlen-1]};
	assign div_diff = div_rem - {1'b0, opd};
	// Borrow means restore
	assign div_next = div_diff[xlen] ? {div_rem[xlen-1:0], acc[xlen-2:0], 1'b0}
	                                 : {div_diff[xlen-1:0], acc[xlen-2:0], 1'b1};

	assign quo_fix = neg_q ? -acc[xlen-1:0] : acc[xlen-1:0];
	assign rem_fix = neg_r ? -acc[2*xlen-1:xlen] : acc[2*xlen-1:xlen];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy   <= 1'b0;
			done   <= 1'b0;
			cnt    <= '0;
			op_div <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy   <= 1'b1;
					op_div <= is_div;
					cnt    <= is_div ? cnt_w'(`EX_DIV_CYCLES - 1) : cnt_w'(`EX_MUL_CYCLES - 1);
				end
			end else if (cnt == '0) begin
				busy <= 1'b0;
				done <= 1'b1;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && start) begin
			opd   <= is_div ? mag_b : mag_a;
			acc   <= {{xlen{1'b0}}, (is_div ? mag_a : mag_b)};
			// Divide by zero keeps the all-ones quotient unsigned
			neg_q <= sign && (srca[xlen-1] ^ srcb[xlen-1]) && !(is_div && srcb == '0);
			// Remainder follows the dividend
			neg_r <= sign && srca[xlen-1];
		end else if (busy) begin
			if (op_div) begin
				if (cnt != '0) begin
					acc <= div_next;
				end else begin
					hi <= rem_fix;
					lo <= quo_fix;
				end
			end else begin
				acc <= mul_next;
				if (cnt == '0) begin
					hi <= mul_res[2*xlen-1:xlen];
					lo <= mul_res[xlen-1:0];
				end
			end
		end
	end

endmodule

/* hw/hilo_regs.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module hilo_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                md_done,
	input  logic [`EX_XLEN-1:0] md_hi,
	input  logic [`EX_XLEN-1:0] md_lo,
	input  logic                hi_wen,
	input  logic                lo_wen,
	input  logic [`EX_XLEN-1:0] wdata,
	output logic [`EX_XLEN-1:0] hi,
	output logic [`EX_XLEN-1:0] lo
);

	// Move-to writes override a muldiv result in the same cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			hi <= '0;
			lo <= '0;
		end else begin
			if (hi_wen) begin
				hi <= wdata;
			end else if (md_done) begin
				hi <= md_hi;
			end

			if (lo_wen) begin
				lo <= wdata;
			end else if (md_done) begin
				lo <= md_lo;
			end
		end
	end

endmodule

/* hw/branch_resolve.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module branch_resolve (
	input  logic                  isbranch,
	input  ex_ctrl_pkg::branch_e  cond,
	input  logic [`EX_XLEN-1:0]   rsdata,
	input  logic [`EX_XLEN-1:0]   rtdata,
	input  logic                  guess_taken,
	output logic                  wrong_guess
);
	import ex_ctrl_pkg::*;

	logic equal;
	logic zero;
	logic gtz;
	logic taken;

	assign equal = rsdata == rtdata;
	assign zero  = rsdata == '0;
	assign gtz   = !rsdata[`EX_XLEN-1] && !zero;

	always_comb begin
		case (cond)
			br_beq:  taken = equal;
			br_bne:  taken = !equal;
			br_bgez: taken = gtz || zero;
			br_bgtz: taken = gtz;
			br_blez: taken = !gtz;
			br_bltz: taken = !gtz && !zero;
			default: taken = 1'b0;
		endcase
	end

	// Only a taken guess can be wrong here since fall-through is fetched anyway
	assign wrong_guess = guess_taken && !(isbranch && taken);

endmodule

/* hw/ex.sv */
`timescale 1ns/1ps
`include "ex_macros.svh"

module ex (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`EX_XLEN-1:0]     rsdata,
	input  logic [`EX_XLEN-1:0]     rtdata,
	input  ex_data_pkg::dp_dtoe     dtoe,
	input  ex_ctrl_pkg::ctrl_reg    esig,
	input  logic                    guess_taken,
	output logic                    wrong_guess,
	output logic                    muldiv_done,
	output ex_data_pkg::dp_etom     etom,
	output ex_data_pkg::dp_etoh     etoh
);
	import ex_ctrl_pkg::*;

	logic [`EX_XLEN-1:0] imm_ext;
	logic [`EX_XLEN-1:0] alu_srcb;
	logic [`EX_XLEN-1:0] alu_out;
	logic                alu_ovf;
	logic [`EX_XLEN-1:0] sft_src;
	logic [4:0]          sft_amt;
	logic [`EX_XLEN-1:0] sft_out;
	logic [`EX_XLEN-1:0] cl_out;
	logic                md_busy;
	logic [`EX_XLEN-1:0] md_hi;
	logic [`EX_XLEN-1:0] md_lo;
	logic [`EX_XLEN-1:0] hi;
	logic [`EX_XLEN-1:0] lo;

	assign imm_ext = esig.imm_sign ? {{(`EX_XLEN-16){dtoe.imm[15]}}, dtoe.imm}
	                               : {{(`EX_XLEN-16){1'b0}}, dtoe.imm};

	// Operand muxes
	assign alu_srcb = esig.alu_srcb_sel_rt  ? rtdata       : imm_ext;
	assign sft_src  = esig.sft_srca_sel_imm ? imm_ext      : rtdata;
	assign sft_amt  = esig.sft_srcb_sel_rs  ? rsdata[4:0]  : dtoe.sa;

	alu u_alu (
		.func   (esig.alu_func),
		.srca   (rsdata),
		.srcb   (alu_srcb),
		.result (alu_out),
		.intovf (alu_ovf)
	);

	bit_unit u_bit_unit (
		.sft_func  (esig.sft_func),
		.shift_src (sft_src),
		.shamt     (sft_amt),
		.cl_mode   (esig.cl_mode),
		.cl_src    (rsdata),
		.shift_out (sft_out),
		.count_out (cl_out)
	);

	muldiv u_muldiv (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (esig.mul_en | esig.div_en),
		.is_div (esig.div_en),
		.sign   (esig.md_sign),
		.srca   (rsdata),
		.srcb   (rtdata),
		.busy   (md_busy),
		.done   (muldiv_done),
		.hi     (md_hi),
		.lo     (md_lo)
	);

	// Move-to instructions write rs
	hilo_regs u_hilo_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.md_done (muldiv_done),
		.md_hi   (md_hi),
		.md_lo   (md_lo),
		.hi_wen  (esig.hi_wen),
		.lo_wen  (esig.lo_wen),
		.wdata   (rsdata),
		.hi      (hi),
		.lo      (lo)
	);

	branch_resolve u_branch_resolve (
		.isbranch    (esig.isbranch),
		.cond        (esig.branch),
		.rsdata      (rsdata),
		.rtdata      (rtdata),
		.guess_taken (guess_taken),
		.wrong_guess (wrong_guess)
	);

	always_comb begin
		case (esig.out_sel)
			out_alu:   etom.ex_out = alu_out;
			out_shift: etom.ex_out = sft_out;
			out_hi:    etom.ex_out = hi;
			out_lo:    etom.ex_out = lo;
			out_count: etom.ex_out = cl_out;
			out_rs:    etom.ex_out = rsdata;
			default:   etom.ex_out = alu_out;
		endcase

		case (esig.regdst)
			regdst_rt:   etom.reg_waddr = dtoe.rt;
			regdst_rd:   etom.reg_waddr = dtoe.rd;
			regdst_link: etom.reg_waddr = 5'(`EX_LINK_REG);
			default:     etom.reg_waddr = dtoe.rt;
		endcase

		etom.intovf = alu_ovf & esig.intovf_en;
		etom.rtdata = rtdata;
		etom.pc     = dtoe.pc;

		etoh.reg_waddr   = etom.reg_waddr;
		etoh.regwrite    = esig.regwrite;
		etoh.rs          = dtoe.rs;
		etoh.rt          = dtoe.rt;
		etoh.muldiv_busy = md_busy;
	end

endmodule

/* test/tb_ex_model.svh */
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

function automatic logic [31:0] imm_extend(input logic [15:0] imm, input logic sign_ext);
	return sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};
endfunction

// Overflow flag in bit 32, result below it
function automatic logic [32:0] alu_ref(input alu_func_e func, input logic [31:0] a,
		input logic [31:0] b);
	logic signed [32:0] wsum;
	logic signed [32:0] wdiff;
	logic [31:0]        res;
	logic               ovf;
	wsum  = $signed({a[31], a}) + $signed({b[31], b});
	wdiff = $signed({a[31], a}) - $signed({b[31], b});
	ovf   = 1'b0;
	case (func)
		alu_add: begin
			res = wsum[31:0];
			ovf = wsum[32] != wsum[31];
		end
		alu_addu: res = wsum[31:0];
		alu_sub: begin
			res = wdiff[31:0];
			ovf = wdiff[32] != wdiff[31];
		end
		alu_subu: res = wdiff[31:0];
		alu_and:  res = a & b;
		alu_or:   res = a | b;
		alu_xor:  res = a ^ b;
		alu_nor:  res = ~(a | b);
		alu_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		alu_sltu: res = (a < b) ? 32'd1 : 32'd0;
		alu_lui:  res = {b[15:0], 16'h0000};
		default:  res = 32'd0;
	endcase
	return {ovf, res};
endfunction

function automatic logic [31:0] shift_ref(input sft_func_e func, input logic [31:0] src,
		input logic [4:0] amt);
	logic [31:0] res;
	res = src;
	case (func)
		sft_sll: res = src << amt;
		sft_srl: res = src >> amt;
		sft_sra: begin
			// Arithmetic shift one sign copy at a time
			for (int k = 0; k < amt; k++) begin
				res = {res[31], res[31:1]};
			end
		end
		default: res = 32'd0;
	endcase
	return res;
endfunction

// Length of the run of bits equal to mode, from the MSB down
function automatic logic [31:0] lead_count(input logic mode, input logic [31:0] w);
	int n;
	n = 0;
	for (int i = 31; i >= 0 && w[i] == mode; i--) begin
		n++;
	end
	return 32'(n);
endfunction

function automatic logic branch_taken(input branch_e cond, input logic [31:0] rs,
		input logic [31:0] rt);
	case (cond)
		br_beq:  return rs == rt;
		br_bne:  return rs != rt;
		br_bgez: return $signed(rs) >= 0;
		br_bgtz: return $signed(rs) > 0;
		br_blez: return $signed(rs) <= 0;
		br_bltz: return $signed(rs) < 0;
		default: return 1'b0;
	endcase
endfunction

function automatic logic guess_wrong(input logic isbranch, input branch_e cond,
		input logic [31:0] rs, input logic [31:0] rt, input logic guess);
	return guess && !(isbranch && branch_taken(cond, rs, rt));
endfunction

function automatic logic [63:0] mul_product(input logic sign, input logic [31:0] a,
		input logic [31:0] b);
	logic signed [63:0] sa;
	logic signed [63:0] sb;
	sa = sign ? {{32{a[31]}}, a} : {32'h0, a};
	sb = sign ? {{32{b[31]}}, b} : {32'h0, b};
	return sa * sb;
endfunction

// Remainder in the upper word, quotient in the lower
function automatic logic [63:0] div_result(input logic sign, input logic [31:0] a,
		input logic [31:0] b);
	logic signed [63:0] sa;
	logic signed [63:0] sb;
	logic signed [63:0] q;
	logic signed [63:0] r;
	if (b == 32'd0) begin
		return {a, 32'hffff_ffff};
	end
	sa = sign ? {{32{a[31]}}, a} : {32'h0, a};
	sb = sign ? {{32{b[31]}}, b} : {32'h0, b};
	q  = sa / sb;
	r  = sa % sb;
	return {r[31:0], q[31:0]};
endfunction

`endif

/* test/tb_ex.sv */
`timescale 1ns/1ps

module tb_ex;
	import ex_ctrl_pkg::*;
	import ex_data_pkg::*;

	`include "tb_ex_model.svh"

	localparam int mul_latency = 32;
	localparam int div_latency = 33;

	logic        clk;
	logic        rst_n;
	logic [31:0] rsdata;
	logic [31:0] rtdata;
	dp_dtoe      dtoe;
	ctrl_reg     esig;
	logic        guess_taken;
	logic        wrong_guess;
	logic        muldiv_done;
	dp_etom      etom;
	dp_etoh      etoh;

	logic [31:0] lfsr = 32'ha113;
	logic [31:0] hi_model;
	logic [31:0] lo_model;

	ex DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.rsdata      (rsdata),
		.rtdata      (rtdata),
		.dtoe        (dtoe),
		.esig        (esig),
		.guess_taken (guess_taken),
		.wrong_guess (wrong_guess),
		.muldiv_done (muldiv_done),
		.etom        (etom),
		.etoh        (etoh)
	);

	always #2 clk = ~clk;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int k = 0; k < n; k++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return val;
	endfunction

	function automatic logic random_bit();
		logic [31:0] b;
		b = random_bits(1);
		return b[0];
	endfunction

	function automatic dp_dtoe random_dtoe();
		dp_dtoe d;
		d.imm = 16'(random_bits(16));
		d.sa  = 5'(random_bits(5));
		d.rs  = 5'(random_bits(5));
		d.rt  = 5'(random_bits(5));
		d.rd  = 5'(random_bits(5));
		d.pc  = random_bits(32);
		return d;
	endfunction

	function automatic ctrl_reg idle_ctrl();
		ctrl_reg c;
		c = '0;
		c.out_sel = out_alu;
		return c;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] want,
			input logic [31:0] got);
		$display("** Error %s: expected %h, actual %h", name, want, got);
		$display("Errors found");
		$fatal(1, "Stopping at the first mismatch");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Errors found");
		$fatal(1, "Stopping on timeout");
	endtask

	task automatic check_value(input string name, input logic [31:0] want,
			input logic [31:0] got);
		assert (got === want) else report_mismatch(name, want, got);
	endtask

	task automatic check_bit(input string name, input logic want, input logic got);
		assert (got === want) else report_mismatch(name, 32'(want), 32'(got));
	endtask

	// Inputs change on the rising edge and outputs are read at the falling edge
	task automatic drive_and_settle(input ctrl_reg c, input logic [31:0] rs,
			input logic [31:0] rt, input dp_dtoe d, input logic guess);
		@(posedge clk);
		esig        <= c;
		rsdata      <= rs;
		rtdata      <= rt;
		dtoe        <= d;
		guess_taken <= guess;
		@(negedge clk);
	endtask

	task automatic show_hilo(input string name);
		ctrl_reg c;
		c = idle_ctrl();
		c.out_sel = out_hi;
		drive_and_settle(c, random_bits(32), random_bits(32), random_dtoe(), 1'b0);
		check_value({name, " hi"}, hi_model, etom.ex_out);
		check_bit({name, " done low"}, 1'b0, muldiv_done);
		c.out_sel = out_lo;
		drive_and_settle(c, random_bits(32), random_bits(32), random_dtoe(), 1'b0);
		check_value({name, " lo"}, lo_model, etom.ex_out);
	endtask

	task automatic alu_tests(input int n);
		ctrl_reg     c;
		dp_dtoe      d;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [32:0] want;
		for (int i = 0; i < n; i++) begin
			c = idle_ctrl();
			c.alu_func        = alu_func_e'(4'(random_bits(4) % 11));
			c.alu_srcb_sel_rt = random_bit();
			c.imm_sign        = random_bit();
			c.intovf_en       = random_bit();
			rs = random_bits(32);
			rt = random_bits(32);
			d  = random_dtoe();
			want = alu_ref(c.alu_func, rs,
				c.alu_srcb_sel_rt ? rt : imm_extend(d.imm, c.imm_sign));
			drive_and_settle(c, rs, rt, d, 1'b0);
			check_value("alu result", want[31:0], etom.ex_out);
			check_bit("alu overflow", want[32] & c.intovf_en, etom.intovf);
			check_value("rtdata pass-through", rt, etom.rtdata);
			check_value("pc pass-through", d.pc, etom.pc);
		end
	endtask

	task automatic shift_count_tests(input int n);
		ctrl_reg     c;
		dp_dtoe      d;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] src;
		logic [1:0]  pick;
		for (int i = 0; i < n; i++) begin
			c = idle_ctrl();
			c.sft_func         = sft_func_e'(2'(random_bits(2) % 3));
			c.sft_srca_sel_imm = random_bit();
			c.sft_srcb_sel_rs  = random_bit();
			c.imm_sign         = random_bit();
			c.out_sel          = out_shift;
			rs = random_bits(32);
			rt = random_bits(32);
			d  = random_dtoe();
			src = c.sft_srca_sel_imm ? imm_extend(d.imm, c.imm_sign) : rt;
			drive_and_settle(c, rs, rt, d, 1'b0);
			check_value("shift result",
				shift_ref(c.sft_func, src, c.sft_srcb_sel_rs ? rs[4:0] : d.sa), etom.ex_out);

			// Count words with runs of every length plus all zeros and all ones
			c = idle_ctrl();
			c.cl_mode = random_bit();
			c.out_sel = out_count;
			pick = 2'(random_bits(2));
			case (pick)
				2'd0:    rs = 32'h0000_0000;
				2'd1:    rs = 32'hffff_ffff;
				2'd2:    rs = random_bits(32) >> random_bits(5);
				default: rs = ~(random_bits(32) >> random_bits(5));
			endcase
			drive_and_settle(c, rs, rt, d, 1'b0);
			check_value("count result", lead_count(c.cl_mode, rs), etom.ex_out);
		end
	endtask

	task automatic branch_tests(input int n);
		ctrl_reg     c;
		logic [31:0] rs;
		logic [31:0] rt;
		logic        guess;
		logic [1:0]  bias;
		for (int i = 0; i < n; i++) begin
			c = idle_ctrl();
			c.branch   = branch_e'(3'(random_bits(3) % 6));
			c.isbranch = random_bit();
			guess = random_bit();
			rs    = random_bits(32);
			rt    = random_bits(32);
			bias  = 2'(random_bits(2));
			if (bias == 2'd0) begin
				rt = rs;
			end else if (bias == 2'd1) begin
				rs = 32'd0;
			end
			drive_and_settle(c, rs, rt, random_dtoe(), guess);
			check_bit("wrong guess", guess_wrong(c.isbranch, c.branch, rs, rt, guess),
				wrong_guess);
		end
	endtask

	task automatic regdst_tests(input int n);
		ctrl_reg     c;
		dp_dtoe      d;
		logic [4:0]  want;
		for (int i = 0; i < n; i++) begin
			c = idle_ctrl();
			c.regdst   = regdst_e'(2'(i % 3));
			c.regwrite = random_bit();
			d = random_dtoe();
			want = (i % 3 == 0) ? d.rt : (i % 3 == 1) ? d.rd : 5'd31;
			drive_and_settle(c, random_bits(32), random_bits(32), d, 1'b0);
			check_value("reg_waddr", 32'(want), 32'(etom.reg_waddr));
			check_value("hazard reg_waddr", 32'(want), 32'(etoh.reg_waddr));
			check_bit("hazard regwrite", c.regwrite, etoh.regwrite);
			check_value("hazard rs", 32'(d.rs), 32'(etoh.rs));
			check_value("hazard rt", 32'(d.rt), 32'(etoh.rt));
		end
	endtask

	task automatic muldiv_case(input logic is_div, input logic sign, input logic [31:0] a,
			input logic [31:0] b);
		ctrl_reg     c;
		ctrl_reg     stray;
		logic [63:0] want;
		int          latency;
		int          cycles;
		latency = is_div ? div_latency : mul_latency;
		want    = is_div ? div_result(sign, a, b) : mul_product(sign, a, b);
		c = idle_ctrl();
		c.mul_en  = !is_div;
		c.div_en  = is_div;
		c.md_sign = sign;
		drive_and_settle(c, a, b, random_dtoe(), 1'b0);
		// The next edge accepts the start
		drive_and_settle(idle_ctrl(), random_bits(32), random_bits(32), random_dtoe(), 1'b0);
		check_bit("muldiv busy", 1'b1, etoh.muldiv_busy);
		cycles = 0;
		while (!muldiv_done && cycles < latency + 8) begin
			stray = idle_ctrl();
			if (cycles == 3) begin
				// Start while busy must be dropped
				stray.mul_en  = random_bit();
				stray.div_en  = !stray.mul_en;
				stray.md_sign = random_bit();
			end
			drive_and_settle(stray, random_bits(32), random_bits(32), random_dtoe(), 1'b0);
			cycles++;
		end
		if (!muldiv_done) begin
			report_timeout(is_div ? "divide done" : "multiply done");
		end
		check_value("muldiv latency", 32'(latency), 32'(cycles));
		hi_model = want[63:32];
		lo_model = want[31:0];
		show_hilo(is_div ? "divide" : "multiply");
		check_bit("muldiv idle", 1'b0, etoh.muldiv_busy);
	endtask

	task automatic move_to_tests(input int n);
		ctrl_reg     c;
		logic [31:0] v;
		for (int i = 0; i < n; i++) begin
			c = idle_ctrl();
			c.hi_wen = random_bit();
			c.lo_wen = random_bit();
			v = random_bits(32);
			drive_and_settle(c, v, random_bits(32), random_dtoe(), 1'b0);
			if (c.hi_wen) begin
				hi_model = v;
			end
			if (c.lo_wen) begin
				lo_model = v;
			end
			show_hilo("move-to");
		end
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		rsdata      = '0;
		rtdata      = '0;
		dtoe        = '0;
		esig        = idle_ctrl();
		guess_taken = 1'b0;
		hi_model    = '0;
		lo_model    = '0;

		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit("reset busy", 1'b0, etoh.muldiv_busy);
		check_bit("reset done", 1'b0, muldiv_done);
		show_hilo("reset");

		alu_tests(400);
		shift_count_tests(300);
		branch_tests(300);
		regdst_tests(30);

		muldiv_case(1'b0, 1'b1, 32'hffff_fffe, 32'h0000_0003);
		muldiv_case(1'b0, 1'b0, 32'hffff_ffff, 32'hffff_ffff);
		muldiv_case(1'b0, 1'b1, 32'h8000_0000, 32'h8000_0000);
		for (int i = 0; i < 8; i++) begin
			muldiv_case(1'b0, random_bit(), random_bits(32), random_bits(32));
		end

		// Negative dividend, zero divisor and the most negative quotient
		muldiv_case(1'b1, 1'b1, 32'hffff_fff9, 32'h0000_0002);
		muldiv_case(1'b1, 1'b0, 32'h1234_5678, 32'h0000_0000);
		muldiv_case(1'b1, 1'b1, 32'h8765_4321, 32'h0000_0000);
		muldiv_case(1'b1, 1'b1, 32'h8000_0000, 32'hffff_ffff);
		for (int i = 0; i < 8; i++) begin
			muldiv_case(1'b1, random_bit(), random_bits(32), random_bits(16) + 32'd1);
		end

		move_to_tests(30);

		$display("No errors");
		$finish;
	end

endmodule

/* ex.f */
+incdir+hw
+incdir+test
hw/ex_data_pkg.sv
hw/ex_ctrl_pkg.sv
hw/alu.sv
hw/bit_unit.sv
hw/muldiv.sv
hw/hilo_regs.sv
hw/branch_resolve.sv
hw/ex.sv
test/tb_ex.sv

/* Bender.yml */
package:
  name: ex

sources:
  - include_dirs:
      - hw
    files:
      - hw/ex_data_pkg.sv
      - hw/ex_ctrl_pkg.sv
      - hw/alu.sv
      - hw/bit_unit.sv
      - hw/muldiv.sv
      - hw/hilo_regs.sv
      - hw/branch_resolve.sv
      - hw/ex.sv
  - target: test
    include_dirs:
      - hw
      - test
    files:
      - test/tb_ex.sv
